//--- Makefile
VERILATOR ?= verilator
TOP ?= cpu_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
logic/cpu_pkg.sv
logic/cword_if.sv
logic/control_sequencer.sv
logic/alu_block.sv
logic/mem_block.sv
logic/bus_join.sv
logic/cpu.sv
test/cpu_tb.sv

//--- logic/alu_block.sv
module alu_block (
    input  logic                        clk,
    input  logic                        rst,
    cword_if.alu_mp                     cw,
    input  logic [cpu_pkg::data_w-1:0]  main_bus,
    output logic [cpu_pkg::data_w-1:0]  acc,
    output logic [cpu_pkg::data_w-1:0]  alu_result,
    output cpu_pkg::flag_t              flags
);

    localparam int w = cpu_pkg::data_w;

    logic [w-1:0] opnd;
    logic [w:0]   wide;
    logic         ovf;

    always_comb begin
        case (cw.alu_fn)
            cpu_pkg::fn_add: wide = {1'b0, acc} + {1'b0, opnd};
            cpu_pkg::fn_sub: wide = {1'b0, acc} - {1'b0, opnd}; // top bit is the borrow.
            cpu_pkg::fn_and: wide = {1'b0, acc & opnd};
            cpu_pkg::fn_or:  wide = {1'b0, acc | opnd};
            cpu_pkg::fn_xor: wide = {1'b0, acc ^ opnd};
            default:         wide = {1'b0, opnd};
        endcase
        alu_result = wide[w-1:0];
        case (cw.alu_fn)
            cpu_pkg::fn_add: ovf = (acc[w-1] == opnd[w-1]) && (alu_result[w-1] != acc[w-1]);
            cpu_pkg::fn_sub: ovf = (acc[w-1] != opnd[w-1]) && (alu_result[w-1] != acc[w-1]);
            default:         ovf = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc   <= '0;
            flags <= '0;
        end else begin
            if (cw.a_load) acc <= main_bus;
            if (cw.flags_load) begin
                flags.zero     <= (alu_result == '0);
                flags.carry    <= wide[w];
                flags.negative <= alu_result[w-1];
                flags.overflow <= ovf;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cw.b_load) opnd <= main_bus;
    end

endmodule

//--- logic/bus_join.sv
module bus_join (
    input  logic                        clk,
    input  logic                        rst,
    cword_if.join_mp                    cw,
    input  logic [cpu_pkg::data_w-1:0]  acc,
    input  logic [cpu_pkg::data_w-1:0]  alu_result,
    input  logic [cpu_pkg::data_w-1:0]  mem_data,
    input  logic [cpu_pkg::addr_w-1:0]  pc,
    output logic [cpu_pkg::data_w-1:0]  main_bus,
    output logic [cpu_pkg::data_w-1:0]  out_data,
    output logic                        out_valid
);

    always_comb begin
        case (cw.bus_src)
            cpu_pkg::src_alu: main_bus = alu_result;
            cpu_pkg::src_mem: main_bus = mem_data;
            cpu_pkg::src_pc:  main_bus = pc;
            default:          main_bus = acc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= cw.out_load; // one cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        if (cw.out_load) out_data <= acc;
    end

endmodule

//--- logic/control_sequencer.sv
module control_sequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  cpu_pkg::instr_u ir,
    input  cpu_pkg::flag_t  flags,
    cword_if.seq_mp         cw,
    output logic            halted
);

    localparam int step_w = $clog2(cpu_pkg::max_steps);

    typedef enum logic [1:0] {st_idle, st_run, st_halt} state_e;

    state_e            state;
    logic [step_w-1:0] step;
    logic [step_w-1:0] last_step;
    cpu_pkg::op_e      op;
    logic              taken;

    assign op = cpu_pkg::op_e'(ir);
    assign halted = (state == st_halt);

    // fixed length per class; never below 2, so fetch steps ignore the old ir.
    always_comb begin
        case (ir.br.cls)
            cpu_pkg::cls_alu: last_step = step_w'(4);
            cpu_pkg::cls_mem: last_step = step_w'(5);
            cpu_pkg::cls_br:  last_step = step_w'(3);
            default:          last_step = step_w'(2);
        endcase
    end

    always_comb begin
        case (ir.br.cond)
            cpu_pkg::cond_always: taken = 1'b1;
            cpu_pkg::cond_zero:   taken = flags.zero;
            cpu_pkg::cond_carry:  taken = flags.carry;
            default:              taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: if (run) state <= st_run; // start only out of reset.
                st_run: begin
                    if (step == last_step) begin
                        step <= '0;
                        if (op == cpu_pkg::hlt) state <= st_halt;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                default: state <= st_halt;
            endcase
        end
    end

    // microcode table.
    always_comb begin
        cw.bus_src    = cpu_pkg::src_acc;
        cw.alu_fn     = cpu_pkg::fn_pass;
        cw.a_load     = 1'b0;
        cw.b_load     = 1'b0;
        cw.flags_load = 1'b0;
        cw.mar_load   = 1'b0;
        cw.ir_load    = 1'b0;
        cw.pc_inc     = 1'b0;
        cw.pc_load    = 1'b0;
        cw.mem_write  = 1'b0;
        cw.out_load   = 1'b0;
        if (state == st_run) begin
            case (step)
                step_w'(0): begin
                    cw.bus_src  = cpu_pkg::src_pc;
                    cw.mar_load = 1'b1;
                end
                step_w'(1): begin
                    cw.bus_src = cpu_pkg::src_mem;
                    cw.ir_load = 1'b1;
                    cw.pc_inc  = 1'b1;
                end
                step_w'(2): begin
                    if (ir.br.cls == cpu_pkg::cls_sys) begin
                        cw.out_load = (op == cpu_pkg::out);
                    end else begin
                        cw.bus_src  = cpu_pkg::src_pc; // fetch the operand byte.
                        cw.mar_load = 1'b1;
                    end
                end
                step_w'(3): begin
                    cw.bus_src  = cpu_pkg::src_mem;
                    cw.b_load   = (ir.br.cls == cpu_pkg::cls_alu);
                    cw.mar_load = (ir.br.cls == cpu_pkg::cls_mem);
                    cw.pc_load  = (ir.br.cls == cpu_pkg::cls_br) && taken;
                    cw.pc_inc   = !cw.pc_load; // skip the target on a failed jump.
                end
                step_w'(4): begin
                    if (ir.alu.cls == cpu_pkg::cls_alu) begin
                        cw.bus_src    = cpu_pkg::src_alu;
                        cw.alu_fn     = ir.alu.fn;
                        cw.a_load     = 1'b1;
                        cw.flags_load = 1'b1;
                    end else if (op == cpu_pkg::ldm) begin
                        cw.bus_src = cpu_pkg::src_mem;
                        cw.b_load  = 1'b1;
                    end else begin
                        cw.mem_write = (op == cpu_pkg::sta);
                    end
                end
                step_w'(5): begin
                    if (op == cpu_pkg::ldm) begin
                        cw.bus_src    = cpu_pkg::src_alu; // pass sets the flags.
                        cw.a_load     = 1'b1;
                        cw.flags_load = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- logic/cpu.sv
module cpu #(
    parameter int mem_depth = 256
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        run,
    input  logic                        load_en,
    input  logic [cpu_pkg::addr_w-1:0]  load_addr,
    input  logic [cpu_pkg::data_w-1:0]  load_data,
    output logic [cpu_pkg::data_w-1:0]  out_data,
    output logic                        out_valid,
    output logic                        halted,
    output cpu_pkg::flag_t              flags
);

    logic [cpu_pkg::data_w-1:0] main_bus;
    logic [cpu_pkg::data_w-1:0] acc;
    logic [cpu_pkg::data_w-1:0] alu_result;
    logic [cpu_pkg::data_w-1:0] mem_data;
    logic [cpu_pkg::addr_w-1:0] pc;
    cpu_pkg::instr_u            ir;

    cword_if cw ();

    control_sequencer ctrl (.clk(clk), .rst(rst), .run(run), .ir(ir), .flags(flags),
        .cw(cw.seq_mp), .halted(halted));

    alu_block alu (.clk(clk), .rst(rst), .cw(cw.alu_mp), .main_bus(main_bus), .acc(acc),
        .alu_result(alu_result), .flags(flags));

    mem_block #(.mem_depth(mem_depth)) mem (.clk(clk), .rst(rst), .cw(cw.mem_mp),
        .main_bus(main_bus), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .mem_data(mem_data), .pc(pc), .ir(ir));

    bus_join join_blk (.clk(clk), .rst(rst), .cw(cw.join_mp), .acc(acc),
        .alu_result(alu_result), .mem_data(mem_data), .pc(pc), .main_bus(main_bus),
        .out_data(out_data), .out_valid(out_valid));

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

    localparam int data_w = 8;
    localparam int addr_w = 8;
    localparam int max_steps = 6; // longest instruction, ldm and sta.

    // top two bits of every opcode.
    typedef enum logic [1:0] {
        cls_sys = 2'b00,
        cls_alu = 2'b01,
        cls_mem = 2'b10,
        cls_br  = 2'b11
    } cls_e;

    typedef enum logic [7:0] {
        nop     = 8'h00,
        out     = 8'h01,
        hlt     = 8'h02,
        lda_imm = 8'h40,
        add_imm = 8'h41,
        sub_imm = 8'h42,
        and_imm = 8'h43,
        or_imm  = 8'h44,
        xor_imm = 8'h45,
        ldm     = 8'h80,
        sta     = 8'h81,
        jmp     = 8'hc0,
        jz      = 8'hc1,
        jc      = 8'hc2
    } op_e;

    typedef enum logic [2:0] {fn_pass, fn_add, fn_sub, fn_and, fn_or, fn_xor} alu_fn_e;

    typedef enum logic [1:0] {cond_always, cond_zero, cond_carry} cond_e;

    typedef union packed {
        struct packed {
            cls_e       cls;
            logic [2:0] rsvd;
            alu_fn_e    fn;   // low bits of alu opcodes.
        } alu;
        struct packed {
            cls_e       cls;
            logic [3:0] rsvd;
            cond_e      cond; // low bits of jump opcodes.
        } br;
    } instr_u;

    typedef enum logic [1:0] {src_acc, src_alu, src_mem, src_pc} bus_src_e;

    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
        logic overflow;
    } flag_t;

endpackage

//--- logic/cword_if.sv
interface cword_if;

    cpu_pkg::bus_src_e bus_src;
    logic              a_load;
    logic              b_load;
    cpu_pkg::alu_fn_e  alu_fn;
    logic              flags_load;
    logic              mar_load;
    logic              ir_load;
    logic              pc_inc;
    logic              pc_load;
    logic              mem_write;
    logic              out_load;

    modport seq_mp (output bus_src, a_load, b_load, alu_fn, flags_load, mar_load,
                    ir_load, pc_inc, pc_load, mem_write, out_load);
    modport alu_mp (input a_load, b_load, alu_fn, flags_load);
    modport mem_mp (input mar_load, ir_load, pc_inc, pc_load, mem_write);
    modport join_mp (input bus_src, out_load);

endinterface

//--- logic/mem_block.sv
module mem_block #(
    parameter int mem_depth = 256
) (
    input  logic                        clk,
    input  logic                        rst,
    cword_if.mem_mp                     cw,
    input  logic [cpu_pkg::data_w-1:0]  main_bus,
    input  logic                        load_en,
    input  logic [cpu_pkg::addr_w-1:0]  load_addr,
    input  logic [cpu_pkg::data_w-1:0]  load_data,
    output logic [cpu_pkg::data_w-1:0]  mem_data,
    output logic [cpu_pkg::addr_w-1:0]  pc,
    output cpu_pkg::instr_u             ir
);

    localparam int idx_w = $clog2(mem_depth);

    logic [cpu_pkg::data_w-1:0] ram [mem_depth];
    logic [cpu_pkg::addr_w-1:0] mar;
    logic [cpu_pkg::addr_w-1:0] rd_addr;
    logic [cpu_pkg::addr_w-1:0] wr_addr;
    logic [cpu_pkg::data_w-1:0] wr_data;
    logic                       wr_en;

    // read follows the address being loaded, so data is ready the next step.
    assign rd_addr = cw.mar_load ? main_bus : mar;

    // load port wins over the microcode.
    always_comb begin
        if (load_en) begin
            wr_en   = 1'b1;
            wr_addr = load_addr;
            wr_data = load_data;
        end else begin
            wr_en   = cw.mem_write;
            wr_addr = mar;
            wr_data = main_bus;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) ram[wr_addr[idx_w-1:0]] <= wr_data;
        mem_data <= ram[rd_addr[idx_w-1:0]];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc  <= '0;
            mar <= '0;
            ir  <= '0; // decodes as nop.
        end else begin
            if (cw.pc_load) begin
                pc <= main_bus;
            end else if (cw.pc_inc) begin
                pc <= pc + 1'b1;
            end
            if (cw.mar_load) mar <= main_bus;
            if (cw.ir_load) ir <= main_bus;
        end
    end

endmodule

//--- test/cpu_tb.sv
module cpu_tb;

    localparam int period = 40;
    localparam int n_tests = 6;
    localparam int test_cycles = 700; // reset, 256 load cycles and the longest run.

    logic           clk;
    logic           rst;
    logic           run;
    logic           load_en;
    logic [7:0]     load_addr;
    logic [7:0]     load_data;
    logic [7:0]     out_data;
    logic           out_valid;
    logic           halted;
    cpu_pkg::flag_t flags;

    logic [7:0]  prog [256];
    int          plen;
    logic [7:0]  got_q [$];
    logic [7:0]  exp_q [$];
    logic [3:0]  exp_flags;
    int          exp_cycles;
    logic [31:0] rng;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    cpu dut (
        .clk(clk),
        .rst(rst),
        .run(run),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .out_data(out_data),
        .out_valid(out_valid),
        .halted(halted),
        .flags(flags)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst && out_valid) got_q.push_back(out_data);
    end

    out_spacing: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !($past(out_valid, 1) || $past(out_valid, 2) || $past(out_valid, 3)))
        else note_failure("two out_valid pulses inside four cycles");

    halt_quiet: assert property (@(posedge clk) disable iff (rst) halted |-> !out_valid)
        else note_failure("out_valid pulsed after halt");

    halt_sticky: assert property (@(posedge clk) disable iff (rst) $past(halted) |-> halted)
        else note_failure("halted fell before reset");

    function automatic logic [7:0] rand_byte();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng[23:16];
    endfunction

    task automatic note_failure(string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_idle();
        check_val("out_valid", {31'h0, out_valid}, 32'h0);
        check_val("halted", {31'h0, halted}, 32'h0);
        check_val("flags", {28'h0, flags}, 32'h0);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        run = 1'b0;
        load_en = 1'b0;
        repeat (2) next_cycle();
        rst = 1'b0;
        check_idle();
    endtask

    task automatic clear_prog();
        for (int a = 0; a < 256; a++) begin
            prog[a] = 8'(a) ^ 8'hc3;
        end
        plen = 0;
    endtask

    task automatic emit(logic [7:0] b);
        prog[plen] = b;
        plen++;
    endtask

    task automatic emit_op(logic [7:0] op, logic [7:0] arg);
        emit(op);
        emit(arg);
    endtask

    // whole RAM image goes in, so the fill bytes are known too.
    task automatic load_program();
        for (int a = 0; a < 256; a++) begin
            load_en = 1'b1;
            load_addr = 8'(a);
            load_data = prog[a];
            next_cycle();
            check_idle();
        end
        load_en = 1'b0;
    endtask

    // ISA level model of the program in prog.
    task automatic run_model();
        logic [7:0] mem [256];
        logic [7:0] pc;
        logic [7:0] op;
        logic [7:0] arg;
        logic [7:0] acc;
        logic       z;
        logic       c;
        logic       n;
        logic       v;
        logic       done;
        int         sres;
        int         guard;
        foreach (mem[i]) mem[i] = prog[i];
        exp_q.delete();
        exp_cycles = 0;
        pc = 8'h00;
        acc = 8'h00;
        {z, c, n, v} = 4'h0;
        done = 1'b0;
        guard = 0;
        while (!done && guard < 1000) begin
            op = mem[pc];
            arg = mem[pc + 8'd1];
            pc = pc + 8'd1;
            guard++;
            case (op)
                cpu_pkg::lda_imm, cpu_pkg::add_imm, cpu_pkg::sub_imm,
                cpu_pkg::and_imm, cpu_pkg::or_imm, cpu_pkg::xor_imm: begin
                    c = 1'b0;
                    v = 1'b0;
                    if (op == cpu_pkg::add_imm) begin
                        c = (int'(acc) + int'(arg)) > 255;
                        sres = int'($signed(acc)) + int'($signed(arg));
                        v = (sres > 127) || (sres < -128);
                        acc = acc + arg;
                    end else if (op == cpu_pkg::sub_imm) begin
                        c = acc < arg; // borrow.
                        sres = int'($signed(acc)) - int'($signed(arg));
                        v = (sres > 127) || (sres < -128);
                        acc = acc - arg;
                    end else if (op == cpu_pkg::and_imm) begin
                        acc = acc & arg;
                    end else if (op == cpu_pkg::or_imm) begin
                        acc = acc | arg;
                    end else if (op == cpu_pkg::xor_imm) begin
                        acc = acc ^ arg;
                    end else begin
                        acc = arg;
                    end
                    z = (acc == 8'h00);
                    n = acc[7];
                    pc = pc + 8'd1;
                    exp_cycles += 5;
                end
                cpu_pkg::ldm: begin
                    acc = mem[arg];
                    {z, c, n, v} = {acc == 8'h00, 1'b0, acc[7], 1'b0};
                    pc = pc + 8'd1;
                    exp_cycles += 6;
                end
                cpu_pkg::sta: begin
                    mem[arg] = acc;
                    pc = pc + 8'd1;
                    exp_cycles += 6;
                end
                cpu_pkg::jmp, cpu_pkg::jz, cpu_pkg::jc: begin
                    if (op == cpu_pkg::jmp || (op == cpu_pkg::jz && z) ||
                        (op == cpu_pkg::jc && c)) begin
                        pc = arg;
                    end else begin
                        pc = pc + 8'd1;
                    end
                    exp_cycles += 4;
                end
                cpu_pkg::out: begin
                    exp_q.push_back(acc);
                    exp_cycles += 3;
                end
                cpu_pkg::hlt: begin
                    done = 1'b1;
                    exp_cycles += 3;
                end
                default: exp_cycles += 3; // nop.
            endcase
        end
        exp_flags = {z, c, n, v};
    endtask

    task automatic run_program();
        int cycles;
        apply_reset();
        load_program();
        run_model();
        got_q.delete();
        run = 1'b1;
        cycles = 0;
        while (!halted && cycles < exp_cycles + 50) begin
            next_cycle();
            cycles++;
        end
        if (!halted) begin
            note_failure("halted never rose");
        end else begin
            check_val("cycle count", cycles - 1, exp_cycles); // first cycle only leaves idle.
        end
        repeat (8) next_cycle();
        assert (halted) else note_failure("halted not held after the run");
        check_val("out count", got_q.size(), exp_q.size());
        foreach (exp_q[i]) begin
            if (i < got_q.size()) check_val("out_data", {24'h0, got_q[i]}, {24'h0, exp_q[i]});
        end
        check_val("flags", {28'h0, flags}, {28'h0, exp_flags});
        run = 1'b0;
    endtask

    task automatic report(int num, string name, int e0);
        tests_run++;
        if (errors == e0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - e0);
        end
    endtask

    task automatic test_idle();
        int e0;
        e0 = errors;
        apply_reset();
        clear_prog();
        emit_op(cpu_pkg::lda_imm, 8'h80);
        emit(cpu_pkg::out);
        emit(cpu_pkg::hlt);
        load_program();
        repeat (16) begin
            next_cycle();
            check_idle();
        end
        report(1, "idle after reset", e0);
    endtask

    task automatic test_random_alu();
        int         e0;
        logic [7:0] op;
        e0 = errors;
        clear_prog();
        emit_op(cpu_pkg::lda_imm, rand_byte());
        emit(cpu_pkg::out);
        repeat (10) begin
            op = 8'h40 + rand_byte() % 8'd6; // lda_imm up to xor_imm.
            emit_op(op, rand_byte());
            emit(cpu_pkg::out);
        end
        emit(cpu_pkg::hlt);
        run_program();
        report(2, "random immediate ops", e0);
    endtask

    task automatic test_memory();
        int e0;
        e0 = errors;
        clear_prog();
        prog[8'hb0] = rand_byte(); // only reaches RAM through the load port.
        emit_op(cpu_pkg::lda_imm, rand_byte());
        emit_op(cpu_pkg::sta, 8'ha0);
        emit_op(cpu_pkg::lda_imm, 8'h00);
        emit_op(cpu_pkg::ldm, 8'ha0);
        emit(cpu_pkg::out);
        emit_op(cpu_pkg::ldm, 8'hb0);
        emit(cpu_pkg::out);
        emit_op(cpu_pkg::ldm, 8'hc7);
        emit(cpu_pkg::out);
        emit(cpu_pkg::hlt);
        run_program();
        report(3, "store and load", e0);
    endtask

    task automatic test_branches();
        int e0;
        e0 = errors;
        clear_prog();
        emit_op(cpu_pkg::lda_imm, 8'h37);
        emit_op(cpu_pkg::sub_imm, 8'h37);
        emit_op(cpu_pkg::jz, 8'h09);
        emit_op(cpu_pkg::lda_imm, 8'h11);
        emit(cpu_pkg::out);
        emit_op(cpu_pkg::lda_imm, 8'h22); // 0x09
        emit(cpu_pkg::out);
        emit_op(cpu_pkg::jc, 8'h11);
        emit_op(cpu_pkg::lda_imm, 8'h33);
        emit(cpu_pkg::out);
        emit_op(cpu_pkg::lda_imm, 8'hf0); // 0x11
        emit_op(cpu_pkg::add_imm, 8'h20);
        emit_op(cpu_pkg::jc, 8'h1a);
        emit_op(cpu_pkg::lda_imm, 8'h44);
        emit(cpu_pkg::out);
        emit_op(cpu_pkg::jz, 8'h21); // 0x1a
        emit_op(cpu_pkg::lda_imm, 8'h55);
        emit(cpu_pkg::out);
        emit_op(cpu_pkg::jmp, 8'h23);
        emit_op(cpu_pkg::lda_imm, 8'h66);
        emit(cpu_pkg::hlt); // 0x23
        run_program();
        report(4, "conditional jumps", e0);
    endtask

    task automatic test_halt();
        int e0;
        e0 = errors;
        clear_prog();
        emit_op(cpu_pkg::lda_imm, rand_byte());
        emit(cpu_pkg::out);
        emit(cpu_pkg::hlt);
        emit(cpu_pkg::out);
        emit_op(cpu_pkg::lda_imm, rand_byte());
        emit(cpu_pkg::out);
        run_program();
        repeat (4) next_cycle();
        assert (halted) else note_failure("halted fell while run was low");
        apply_reset();
        report(5, "halt", e0);
    endtask

    task automatic test_out_spacing();
        int e0;
        e0 = errors;
        clear_prog();
        emit_op(cpu_pkg::lda_imm, rand_byte());
        emit(cpu_pkg::out);
        emit(cpu_pkg::nop);
        emit(cpu_pkg::out);
        emit_op(cpu_pkg::sub_imm, rand_byte());
        emit(cpu_pkg::out);
        emit_op(cpu_pkg::xor_imm, rand_byte());
        emit(cpu_pkg::out);
        emit(cpu_pkg::hlt);
        run_program();
        report(6, "dense outputs", e0);
    endtask

    initial begin
        rst = 1'b1;
        run = 1'b0;
        load_en = 1'b0;
        load_addr = 8'h00;
        load_data = 8'h00;
        rng = 32'h5f16_8ef1;
        test_idle();
        test_random_alu();
        test_memory();
        test_branches();
        test_halt();
        test_out_spacing();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(n_tests * test_cycles * period);
        $display("timeout: the tests did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
